//--- include/ex1_params.svh
// ######################################
// EX1 stage shared widths and encodings
// Data, address and register-id widths,
// fixed register ids, memory opcodes
// and trap codes
// ######################################

`ifndef EX1_PARAMS_SVH
`define EX1_PARAMS_SVH

// Widths
`define EX1_DATA_W    64
`define EX1_ADDR_W    32
`define EX1_GPR_ID_W  6
`define EX1_CR_ID_W   5
`define EX1_OPM_W     5
`define EX1_TRAP_W    16

// Fixed register ids
`define EX1_GPR_ZZR   6'h3F  // No GPR target
`define EX1_CR_ZZR    5'h1F  // No CR target
`define EX1_CR_PC     5'h00

// Memory opcodes, {dir[1:0], ext, size[1:0]}
`define EX1_OPM_READY 5'b00000
`define EX1_OPM_RD_Q  5'b01011
`define EX1_OPM_WR_Q  5'b10011

// Trap codes
`define EX1_TRAP_RTE        16'hFF00
`define EX1_TRAP_TRAPA_BASE 12'hC08  // Low nibble is the trap number

`endif

//--- design/ex1Pkg.sv
// ######################################
// EX1 stage types
// Opcode enums and the packed structs
// passed between the stage blocks
// ######################################

`include "ex1_params.svh"

package ex1Pkg;

	// Major micro-op codes
	typedef enum logic [5:0] {
		UCMD_NOP, UCMD_INVOP, UCMD_LEA_MR, UCMD_MOV_RM,
		UCMD_MOV_MR, UCMD_PUSHX, UCMD_POPX, UCMD_MOV_RC,
		UCMD_MOV_CR, UCMD_MOV_IR, UCMD_BRA, UCMD_BRA_NB,
		UCMD_BSR, UCMD_JMP, UCMD_JSR, UCMD_OP_IXT
	} ucmdOpT;

	// Sub-ops of OP_IXT, carried in ixt[5:0]
	typedef enum logic [5:0] {
		IXT_NOP, IXT_SLEEP, IXT_BREAK, IXT_CLRT, IXT_SETT, IXT_CLRS,
		IXT_SETS, IXT_NOTT, IXT_NOTS, IXT_RTE, IXT_TRAPA
	} ixtOpT;

	typedef enum logic [1:0] {
		COND_AL = 2'd0,  // Always
		COND_NV = 2'd1,  // Never
		COND_CT = 2'd2,  // If SR.T set
		COND_CF = 2'd3   // If SR.T clear
	} condT;

	typedef struct packed {
		condT        cond;
		ucmdOpT      opcode;
		logic [7:0]  ixt;  // Bits 7:6 reserved
	} microOpT;

	typedef struct packed {
		logic [`EX1_GPR_ID_W-1:0] idRs;   // Base / ALU source A
		logic [`EX1_GPR_ID_W-1:0] idRt;   // Index / ALU source B
		logic [`EX1_GPR_ID_W-1:0] idRm;   // Destination or store source
		logic [`EX1_DATA_W-1:0]   valRs;
		logic [`EX1_DATA_W-1:0]   valRt;
		logic [`EX1_DATA_W-1:0]   valRm;
		logic [`EX1_DATA_W-1:0]   valCRm;
		logic [`EX1_ADDR_W-1:0]   valPc;  // Return / next PC
		logic [`EX1_ADDR_W:0]     valImm; // 33-bit decoded immediate
	} srcOperandsT;

	typedef struct packed {
		logic [`EX1_DATA_W-1:0] sp;
		logic [`EX1_ADDR_W-1:0] lr;
		logic [`EX1_DATA_W-1:0] sr;
	} specialRegsT;

	typedef struct packed {
		logic [`EX1_GPR_ID_W-1:0] id;
		logic [`EX1_DATA_W-1:0]   value;
	} gprWriteT;

	typedef struct packed {
		logic [`EX1_CR_ID_W-1:0] id;
		logic [`EX1_DATA_W-1:0]  value;
	} crWriteT;

	typedef struct packed {
		logic [`EX1_ADDR_W-1:0] addr;
		logic [`EX1_OPM_W-1:0]  opm;
		logic [`EX1_DATA_W-1:0] data;
	} memReqT;

	// Effective command after condition gating
	typedef struct packed {
		ucmdOpT     opcode;
		logic [5:0] ixt;
		logic       valid;  // Op passed its condition check
	} exCmdT;

	typedef struct packed {
		gprWriteT                 gprWrite;
		logic [`EX1_GPR_ID_W-1:0] heldGprId;
		crWriteT                  crWrite;
		specialRegsT              specialRegs;
		memReqT                   memReq;
		logic [`EX1_TRAP_W-1:0]   trapCode;
		logic                     hold;
	} stageResultT;

endpackage

//--- design/ex1Decode.sv
// ######################################
// EX1 condition decode
// Gates the micro-op on SR.T and branch
// flush, gives the effective command
// ######################################

`timescale 1ns/1ps

module ex1Decode (
	input  ex1Pkg::microOpT opIn,
	input  logic            braFlush,
	input  logic            srT,
	output ex1Pkg::exCmdT   cmd
);

	logic opEnable;

	// Condition code check
	always_comb begin
		case (opIn.cond)
			ex1Pkg::COND_AL: opEnable = 1'b1;
			ex1Pkg::COND_NV: opEnable = 1'b0;
			ex1Pkg::COND_CT: opEnable = srT;
			default:         opEnable = !srT;  // CF
		endcase

		// A flushed slot never executes
		if (braFlush) begin
			opEnable = 1'b0;
		end
	end

	// Effective opcode
	always_comb begin
		cmd.ixt   = opIn.ixt[5:0];
		cmd.valid = opEnable;

		if (opEnable) begin
			cmd.opcode = opIn.opcode;
		end else if (!braFlush && opIn.opcode == ex1Pkg::UCMD_BRA) begin
			// Predicted branch not taken after all, undo it
			cmd.opcode = ex1Pkg::UCMD_BRA_NB;
		end else begin
			cmd.opcode = ex1Pkg::UCMD_NOP;
		end
	end

endmodule

//--- design/ex1Execute.sv
// ######################################
// EX1 execute
// Address generation and per-op results
// for GPR, CR, SP/LR/SR, memory and traps
// ######################################

`timescale 1ns/1ps

`include "ex1_params.svh"

module ex1Execute (
	input  ex1Pkg::exCmdT       cmd,
	input  ex1Pkg::srcOperandsT srcIn,
	input  ex1Pkg::specialRegsT sprIn,
	input  logic                preBra,
	output ex1Pkg::stageResultT result
);

	localparam int padW = `EX1_DATA_W - `EX1_ADDR_W;

	logic [`EX1_ADDR_W-1:0] aguAddr;
	logic [`EX1_DATA_W-1:0] spInc;
	logic [`EX1_DATA_W-1:0] spDec;
	logic                   holdReq;

	// Base plus scaled index
	assign aguAddr = srcIn.valRs[`EX1_ADDR_W-1:0] +
		(srcIn.valRt[`EX1_ADDR_W-1:0] << cmd.ixt[5:4]);

	// Stack moves in 8-byte steps within the low 28 bits
	assign spInc = {sprIn.sp[63:28], sprIn.sp[27:3] + 25'h1, sprIn.sp[2:0]};
	assign spDec = {sprIn.sp[63:28], sprIn.sp[27:3] - 25'h1, sprIn.sp[2:0]};

	always_comb begin
		result.gprWrite.id    = `EX1_GPR_ZZR;
		result.gprWrite.value = '0;
		result.heldGprId      = `EX1_GPR_ZZR;
		result.crWrite.id     = `EX1_CR_ZZR;
		result.crWrite.value  = '0;
		result.specialRegs    = sprIn;
		result.memReq.addr    = aguAddr;
		result.memReq.opm     = `EX1_OPM_READY;
		result.memReq.data    = srcIn.valRm;
		result.trapCode       = '0;
		holdReq               = 1'b0;

		case (cmd.opcode)
			ex1Pkg::UCMD_NOP: begin
			end
			ex1Pkg::UCMD_INVOP: holdReq = 1'b1;
			ex1Pkg::UCMD_LEA_MR: begin
				result.gprWrite.id    = srcIn.idRm;
				result.gprWrite.value = {{padW{1'b0}}, aguAddr};
			end
			ex1Pkg::UCMD_MOV_RM: begin  // Store
				result.memReq.opm = {2'b10, cmd.ixt[2], cmd.ixt[5:4]};
			end
			ex1Pkg::UCMD_MOV_MR: begin  // Load
				result.memReq.opm = {2'b01, cmd.ixt[2], cmd.ixt[5:4]};
				result.heldGprId  = srcIn.idRm;
			end
			ex1Pkg::UCMD_PUSHX: begin
				result.memReq.addr     = spDec[`EX1_ADDR_W-1:0];
				result.memReq.opm      = `EX1_OPM_WR_Q;
				result.specialRegs.sp  = spDec;
				result.memReq.data     = (cmd.ixt[1:0] == 2'd1) ? srcIn.valCRm : srcIn.valRs;
			end
			ex1Pkg::UCMD_POPX: begin
				result.memReq.addr    = sprIn.sp[`EX1_ADDR_W-1:0];  // Old SP
				result.memReq.opm     = `EX1_OPM_RD_Q;
				result.specialRegs.sp = spInc;
			end
			ex1Pkg::UCMD_MOV_RC: begin
				result.crWrite.id    = srcIn.idRm[`EX1_CR_ID_W-1:0];
				result.crWrite.value = srcIn.valRs;
			end
			ex1Pkg::UCMD_MOV_CR: begin
				result.gprWrite.id    = srcIn.idRm;
				result.gprWrite.value = srcIn.valCRm;
			end
			ex1Pkg::UCMD_MOV_IR: begin
				result.gprWrite.id = srcIn.idRm;
				case (cmd.ixt[3:0])
					4'd0: result.gprWrite.value = {{(padW-1){srcIn.valImm[32]}}, srcIn.valImm};
					4'd1: result.gprWrite.value = {srcIn.valRs[55:0], srcIn.valImm[7:0]};
					4'd2: result.gprWrite.value = {srcIn.valRs[47:0], srcIn.valImm[15:0]};
					4'd3: result.gprWrite.value = {srcIn.valRs[31:0], srcIn.valImm[31:0]};
					default: result.gprWrite.value = srcIn.valRt;  // JLDIX
				endcase
			end
			ex1Pkg::UCMD_BRA: begin
				if (!preBra) begin  // Not already taken in fetch
					result.crWrite.id    = `EX1_CR_PC;
					result.crWrite.value = {{padW{1'b0}}, aguAddr};
				end
			end
			ex1Pkg::UCMD_BRA_NB: begin
				// Predicted taken but not executed, back to the fall-through PC
				if (preBra) begin
					result.crWrite.id    = `EX1_CR_PC;
					result.crWrite.value = {{padW{1'b0}}, srcIn.valPc};
				end
			end
			ex1Pkg::UCMD_BSR: begin
				result.specialRegs.lr = srcIn.valPc;
				if (!preBra) begin
					result.crWrite.id    = `EX1_CR_PC;
					result.crWrite.value = {{padW{1'b0}}, aguAddr};
				end
			end
			ex1Pkg::UCMD_JMP: begin
				result.crWrite.id    = `EX1_CR_PC;
				result.crWrite.value = {{padW{1'b0}}, srcIn.valRs[`EX1_ADDR_W-1:0]};
			end
			ex1Pkg::UCMD_JSR: begin
				result.specialRegs.lr = srcIn.valPc;
				result.crWrite.id     = `EX1_CR_PC;
				result.crWrite.value  = {{padW{1'b0}}, srcIn.valRs[`EX1_ADDR_W-1:0]};
			end
			ex1Pkg::UCMD_OP_IXT: begin
				case (cmd.ixt)
					ex1Pkg::IXT_NOP, ex1Pkg::IXT_SLEEP: begin
					end
					ex1Pkg::IXT_BREAK: holdReq = 1'b1;
					ex1Pkg::IXT_CLRT:  result.specialRegs.sr[0] = 1'b0;
					ex1Pkg::IXT_SETT:  result.specialRegs.sr[0] = 1'b1;
					ex1Pkg::IXT_CLRS:  result.specialRegs.sr[1] = 1'b0;
					ex1Pkg::IXT_SETS:  result.specialRegs.sr[1] = 1'b1;
					ex1Pkg::IXT_NOTT:  result.specialRegs.sr[0] = !sprIn.sr[0];
					ex1Pkg::IXT_NOTS:  result.specialRegs.sr[1] = !sprIn.sr[1];
					ex1Pkg::IXT_RTE:   result.trapCode = `EX1_TRAP_RTE;
					ex1Pkg::IXT_TRAPA: result.trapCode = {`EX1_TRAP_TRAPA_BASE, srcIn.idRm[3:0]};
					default:           holdReq = 1'b1;  // Unhandled sub-op
				endcase
			end
			default: holdReq = 1'b1;  // Unknown opcode
		endcase

		// Only a live op can stall the core
		result.hold = holdReq & cmd.valid;
	end

endmodule

//--- design/ex1Result.sv
// ######################################
// EX1 result register
// Holds all stage outputs for one cycle,
// idle values on reset
// ######################################

`timescale 1ns/1ps

`include "ex1_params.svh"

module ex1Result (
	input  logic                clock,
	input  logic                rstN,
	input  ex1Pkg::stageResultT next,
	output ex1Pkg::stageResultT out
);

	// Nothing targeted, memory idle, no trap
	localparam ex1Pkg::stageResultT idleResult = '{
		gprWrite: '{
			id:    `EX1_GPR_ZZR,
			value: '0
		},
		heldGprId: `EX1_GPR_ZZR,
		crWrite: '{
			id:    `EX1_CR_ZZR,
			value: '0
		},
		specialRegs: '0,
		memReq: '{
			addr: '0,
			opm:  `EX1_OPM_READY,
			data: '0
		},
		trapCode: '0,
		hold:     1'b0
	};

	always_ff @(posedge clock) begin
		if (!rstN) begin
			out <= idleResult;
		end else begin
			out <= next;  // One cycle latency
		end
	end

endmodule

//--- design/ex1Stage.sv
// ######################################
// EX1 stage top
// Condition decode, execute and the
// output register, one op per cycle
// ######################################

`timescale 1ns/1ps

module ex1Stage (
	input  logic                clock,
	input  logic                rstN,
	input  ex1Pkg::microOpT     opIn,
	input  ex1Pkg::srcOperandsT srcIn,
	input  ex1Pkg::specialRegsT sprIn,
	input  logic                braFlush,
	input  logic                preBra,
	output ex1Pkg::gprWriteT    gprWrite,
	output logic [5:0]          heldGprId,
	output ex1Pkg::crWriteT     crWrite,
	output ex1Pkg::specialRegsT sprOut,
	output ex1Pkg::memReqT      memReq,
	output logic [15:0]         trapCode,
	output logic                hold
);

	ex1Pkg::exCmdT       cmd;
	ex1Pkg::stageResultT nextResult;
	ex1Pkg::stageResultT result;

	ex1Decode uDecode (
		.opIn     (opIn),
		.braFlush (braFlush),
		.srT      (sprIn.sr[0]),  // SR.T
		.cmd      (cmd)
	);

	ex1Execute uExecute (
		.cmd    (cmd),
		.srcIn  (srcIn),
		.sprIn  (sprIn),
		.preBra (preBra),
		.result (nextResult)
	);

	ex1Result uResult (
		.clock (clock),
		.rstN  (rstN),
		.next  (nextResult),
		.out   (result)
	);

	assign gprWrite  = result.gprWrite;
	assign heldGprId = result.heldGprId;
	assign crWrite   = result.crWrite;
	assign sprOut    = result.specialRegs;
	assign memReq    = result.memReq;
	assign trapCode  = result.trapCode;
	assign hold      = result.hold;

endmodule

//--- dv/ex1_assert.sv
// ######################################
// EX1 stage assertions
// Reset idle memory, trap and hold rules
// ######################################

`timescale 1ns/1ps

`include "ex1_params.svh"

module ex1StageAssert (
	input logic                clock,
	input logic                rstN,
	input ex1Pkg::memReqT      memReq,
	input ex1Pkg::crWriteT     crWrite,
	input logic [15:0]         trapCode,
	input logic                hold
);

	// Output is registered, so look one edge after reset is seen
	assert property (@(posedge clock) !rstN |=> memReq.opm == `EX1_OPM_READY)
		else $error("memory request during reset");

	assert property (@(posedge clock) disable iff (!rstN) hold |-> trapCode == '0)
		else $error("trap code raised together with hold");

	assert property (@(posedge clock) disable iff (!rstN)
		crWrite.id == `EX1_CR_PC |-> memReq.opm == `EX1_OPM_READY)
		else $error("PC write together with a memory request");

endmodule

bind ex1Stage ex1StageAssert uStageAssert (
	.clock    (clock),
	.rstN     (rstN),
	.memReq   (memReq),
	.crWrite  (crWrite),
	.trapCode (trapCode),
	.hold     (hold)
);

//--- dv/ex1Tb.sv
// ######################################
// EX1 stage testbench
// Pattern-driven stimulus, one op per
// cycle, checks each registered result
// ######################################

`timescale 1ns/1ps

`include "ex1_params.svh"

module ex1Tb;

	logic                clock;
	logic                rstN;
	ex1Pkg::microOpT     opIn;
	ex1Pkg::srcOperandsT srcIn;
	ex1Pkg::specialRegsT sprIn;
	logic                braFlush;
	logic                preBra;
	ex1Pkg::gprWriteT    gprWrite;
	logic [5:0]          heldGprId;
	ex1Pkg::crWriteT     crWrite;
	ex1Pkg::specialRegsT sprOut;
	ex1Pkg::memReqT      memReq;
	logic [15:0]         trapCode;
	logic                hold;

	// Test vectors, one entry per pattern line
	logic [7:0]          nameQ[$];
	ex1Pkg::microOpT     opQ[$];
	ex1Pkg::srcOperandsT srcQ[$];
	ex1Pkg::specialRegsT sprQ[$];
	logic [1:0]          ctlQ[$];  // {braFlush, preBra}
	ex1Pkg::stageResultT expQ[$];

	logic [31:0] lfsrState = 32'h5190;
	int          numTests  = 0;
	logic        loaded    = 1'b0;
	int          testErr   = 0;
	int          failCount = 0;
	int          passCount = 0;

	ex1Stage DUT (
		.clock     (clock),
		.rstN      (rstN),
		.opIn      (opIn),
		.srcIn     (srcIn),
		.sprIn     (sprIn),
		.braFlush  (braFlush),
		.preBra    (preBra),
		.gprWrite  (gprWrite),
		.heldGprId (heldGprId),
		.crWrite   (crWrite),
		.sprOut    (sprOut),
		.memReq    (memReq),
		.trapCode  (trapCode),
		.hold      (hold)
	);

	always #4 clock = !clock;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic drawBits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[62:0], lfsrState[0]};
		end
	endtask

	task automatic checkGpr(input ex1Pkg::gprWriteT got, input ex1Pkg::gprWriteT exp,
			input logic [5:0] gotHeld, input logic [5:0] expHeld);
		if (got !== exp) begin
			$display("** Error: gprWrite got %h expected %h", got, exp);
			testErr++;
		end
		if (gotHeld !== expHeld) begin
			$display("** Error: heldGprId got %h expected %h", gotHeld, expHeld);
			testErr++;
		end
	endtask

	task automatic checkCr(input ex1Pkg::crWriteT got, input ex1Pkg::crWriteT exp);
		if (got !== exp) begin
			$display("** Error: crWrite got %h expected %h", got, exp);
			testErr++;
		end
	endtask

	task automatic checkMem(input ex1Pkg::memReqT got, input ex1Pkg::memReqT exp);
		if (got !== exp) begin
			$display("** Error: memReq got %h expected %h", got, exp);
			testErr++;
		end
	endtask

	task automatic checkSpr(input ex1Pkg::specialRegsT got, input ex1Pkg::specialRegsT exp);
		if (got !== exp) begin
			$display("** Error: sprOut got %h expected %h", got, exp);
			testErr++;
		end
	endtask

	task automatic checkTrap(input logic [15:0] gotTrap, input logic gotHold,
			input logic [15:0] expTrap, input logic expHold);
		if (gotTrap !== expTrap) begin
			$display("** Error: trapCode got %h expected %h", gotTrap, expTrap);
			testErr++;
		end
		if (gotHold !== expHold) begin
			$display("** Error: hold got %h expected %h", gotHold, expHold);
			testErr++;
		end
	endtask

	// Every stage output against one expected result
	task automatic compareAll(input ex1Pkg::stageResultT exp);
		checkGpr(gprWrite, exp.gprWrite, heldGprId, exp.heldGprId);
		checkCr(crWrite, exp.crWrite);
		checkMem(memReq, exp.memReq);
		checkSpr(sprOut, exp.specialRegs);
		checkTrap(trapCode, hold, exp.trapCode, exp.hold);
	endtask

	task automatic readPatterns();
		int                  fd;
		int                  n;
		string               line;
		logic [63:0]         f [0:30];
		logic [63:0]         v;
		ex1Pkg::microOpT     op;
		ex1Pkg::srcOperandsT src;
		ex1Pkg::specialRegsT spr;
		ex1Pkg::stageResultT exp;
		fd = $fopen("dv/ex1_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line[0] == 8'h23) begin
				continue;  // Blank or comment
			end
			n = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
				f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
				f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29], f[30]);
			if (n != 31) begin
				$display("Malformed pattern line skipped");
				failCount++;
				continue;
			end
			op.cond   = ex1Pkg::condT'(f[1][1:0]);
			op.opcode = ex1Pkg::ucmdOpT'(f[2][5:0]);
			op.ixt    = f[3][7:0];
			drawBits(6, v);  // FF marks a don't-care id
			src.idRs   = (f[4] == 64'hFF) ? v[5:0] : f[4][5:0];
			drawBits(6, v);
			src.idRt   = (f[5] == 64'hFF) ? v[5:0] : f[5][5:0];
			src.idRm   = f[6][5:0];
			src.valRs  = f[7];
			src.valRt  = f[8];
			src.valRm  = f[9];
			src.valCRm = f[10];
			src.valPc  = f[11][31:0];
			src.valImm = f[12][32:0];
			spr.sp     = f[13];
			spr.lr     = f[14][31:0];
			spr.sr     = f[15];
			exp.gprWrite.id       = f[18][5:0];
			exp.gprWrite.value    = f[19];
			exp.heldGprId         = f[20][5:0];
			exp.crWrite.id        = f[21][4:0];
			exp.crWrite.value     = f[22];
			exp.specialRegs.sp    = f[23];
			exp.specialRegs.lr    = f[24][31:0];
			exp.specialRegs.sr    = f[25];
			exp.memReq.addr       = f[26][31:0];
			exp.memReq.opm        = f[27][4:0];
			exp.memReq.data       = f[28];
			exp.trapCode          = f[29][15:0];
			exp.hold              = f[30][0];
			nameQ.push_back(f[0][7:0]);
			opQ.push_back(op);
			srcQ.push_back(src);
			sprQ.push_back(spr);
			ctlQ.push_back({f[16][0], f[17][0]});
			expQ.push_back(exp);
		end
		$fclose(fd);
	endtask

	// Watchdog sized from the number of tests
	initial begin
		wait (loaded);
		#((numTests + 20) * 8);
		$display("Watchdog timeout, the tests did not complete");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		ex1Pkg::gprWriteT    idleGpr;
		ex1Pkg::crWriteT     idleCr;
		ex1Pkg::memReqT      idleMem;
		ex1Pkg::stageResultT prevExp;
		int                  earlyErr;
		clock    = 1'b0;
		rstN     = 1'b0;
		opIn     = '0;
		srcIn    = '0;
		sprIn    = '0;
		braFlush = 1'b0;
		preBra   = 1'b0;
		readPatterns();
		numTests = nameQ.size();
		loaded   = 1'b1;
		if (numTests == 0) begin
			$display("No tests were read from the pattern file");
			failCount++;
		end

		// Reset values
		repeat (8) @(posedge clock);
		#1;
		idleGpr = '{id: `EX1_GPR_ZZR, value: '0};
		idleCr  = '{id: `EX1_CR_ZZR, value: '0};
		idleMem = '{addr: '0, opm: `EX1_OPM_READY, data: '0};
		prevExp = '{
			gprWrite:    idleGpr,
			heldGprId:   `EX1_GPR_ZZR,
			crWrite:     idleCr,
			specialRegs: '0,
			memReq:      idleMem,
			trapCode:    16'h0,
			hold:        1'b0
		};
		testErr = 0;
		compareAll(prevExp);
		if (testErr == 0) begin
			passCount++;
		end else begin
			failCount++;
		end
		$display("test reset %s", (testErr == 0) ? "ok" : "failed");
		rstN = 1'b1;

		for (int i = 0; i < numTests; i++) begin
			opIn     = opQ[i];  // Driven 1 ns after the edge
			srcIn    = srcQ[i];
			sprIn    = sprQ[i];
			braFlush = ctlQ[i][1];
			preBra   = ctlQ[i][0];
			testErr  = 0;

			// Just before the edge the previous result must still be held
			#6;
			compareAll(prevExp);
			earlyErr = testErr;
			if (earlyErr != 0) begin
				$display("Result of test %h changed before its clock edge", nameQ[i]);
			end

			@(posedge clock);
			#1;
			compareAll(expQ[i]);
			if (testErr == 0) begin
				passCount++;
			end else begin
				failCount++;
			end
			$display("test %h %s", nameQ[i], (testErr == 0) ? "ok" : "failed");
			prevExp = expQ[i];
		end

		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- dv/ex1_patterns.txt
# name cond op ixt idRs idRt idRm valRs valRt valRm valCRm valPc valImm sp lr sr flush pre
# then gprId gprVal held crId crVal sp lr sr addr opm data trap hold (FF id = don't care)
01 0 00 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
02 0 02 10 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 05 110 3F 1F 0 8000 0 0 110 00 DA7A 0 0
03 0 03 34 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 140 17 DA7A 0 0
04 0 04 30 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 05 1F 0 8000 0 0 140 0B DA7A 0 0
05 0 05 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 7FF8 0 0 7FF8 13 100 0 0
06 0 05 01 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 7FF8 0 0 7FF8 13 C0 0 0
07 0 06 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8008 0 0 8000 0B DA7A 0 0
08 0 07 00 FF FF 25 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 05 100 8000 0 0 108 00 DA7A 0 0
09 0 08 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 05 C0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
0A 0 09 00 FF FF 05 100 8 DA7A C0 2000 1FFFF0000 8000 0 0 0 0 05 FFFFFFFFFFFF0000 3F 1F 0 8000 0 0 108 00 DA7A 0 0
0B 0 09 00 FF FF 05 100 8 DA7A C0 2000 ABCD 8000 0 0 0 0 05 ABCD 3F 1F 0 8000 0 0 108 00 DA7A 0 0
0C 0 09 01 FF FF 05 100 8 DA7A C0 2000 AB 8000 0 0 0 0 05 100AB 3F 1F 0 8000 0 0 108 00 DA7A 0 0
0D 0 09 02 FF FF 05 100 8 DA7A C0 2000 1234 8000 0 0 0 0 05 1001234 3F 1F 0 8000 0 0 108 00 DA7A 0 0
0E 0 09 03 FF FF 05 100 8 DA7A C0 2000 DEADBEEF 8000 0 0 0 0 05 100DEADBEEF 3F 1F 0 8000 0 0 108 00 DA7A 0 0
0F 0 09 04 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 05 8 3F 1F 0 8000 0 0 108 00 DA7A 0 0
10 0 0A 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 00 108 8000 0 0 108 00 DA7A 0 0
11 0 0A 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 1 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
12 0 0C 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 00 108 8000 2000 0 108 00 DA7A 0 0
13 0 0D 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 00 100 8000 0 0 108 00 DA7A 0 0
14 0 0E 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 00 100 8000 2000 0 108 00 DA7A 0 0
15 2 02 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 1 0 0 05 108 3F 1F 0 8000 0 1 108 00 DA7A 0 0
16 2 02 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
17 3 02 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 05 108 3F 1F 0 8000 0 0 108 00 DA7A 0 0
18 1 02 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
19 0 02 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 1 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
1A 1 0A 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 1 3F 0 3F 00 2000 8000 0 0 108 00 DA7A 0 0
1B 0 0A 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 1 1 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 0
1C 0 0F 03 FF FF 05 100 8 DA7A C0 2000 0 8000 0 3 0 0 3F 0 3F 1F 0 8000 0 2 108 00 DA7A 0 0
1D 0 0F 04 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 1 108 00 DA7A 0 0
1E 0 0F 05 FF FF 05 100 8 DA7A C0 2000 0 8000 0 3 0 0 3F 0 3F 1F 0 8000 0 1 108 00 DA7A 0 0
1F 0 0F 06 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 2 108 00 DA7A 0 0
20 0 0F 07 FF FF 05 100 8 DA7A C0 2000 0 8000 0 2 0 0 3F 0 3F 1F 0 8000 0 3 108 00 DA7A 0 0
21 0 0F 08 FF FF 05 100 8 DA7A C0 2000 0 8000 0 3 0 0 3F 0 3F 1F 0 8000 0 1 108 00 DA7A 0 0
22 0 0F 09 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A FF00 0
23 0 0F 0A FF FF 2B 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A C08B 0
24 0 01 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 1
25 0 0F 02 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 1
26 0 3F 00 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 108 00 DA7A 0 1
27 0 0F 20 FF FF 05 100 8 DA7A C0 2000 0 8000 0 0 0 0 3F 0 3F 1F 0 8000 0 0 120 00 DA7A 0 1

//--- flist.f
+incdir+include
design/ex1Pkg.sv
design/ex1Decode.sv
design/ex1Execute.sv
design/ex1Result.sv
design/ex1Stage.sv
dv/ex1_assert.sv
dv/ex1Tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the EX1 stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module ex1Tb -o simv || exit 1

./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}
